// ==== Bender.yml ====
package:
  name: cr16

sources:
  - verilog/cr16_isa_pkg.sv
  - verilog/cr16_core_pkg.sv
  - verilog/cr16_decode.sv
  - verilog/cr16_alu.sv
  - verilog/cr16_regfile.sv
  - verilog/cr16_control.sv
  - verilog/cr16_top.sv
  - target: test
    files:
      - tests/cr16_tb.sv

// ==== build.f ====
verilog/cr16_isa_pkg.sv
verilog/cr16_core_pkg.sv
verilog/cr16_decode.sv
verilog/cr16_alu.sv
verilog/cr16_regfile.sv
verilog/cr16_control.sv
verilog/cr16_top.sv
tests/cr16_tb.sv

// ==== tests/cr16_tb.sv ====
// CR16 core testbench with a synchronous-read memory model and directed program tests
module cr16_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cr16_isa_pkg::*;

    // All programs together run for about 1100 cycles including resets
    localparam int test_cycles = 1100;
    localparam int max_cycles  = 2 * test_cycles;

    logic        I_CLK;
    logic        I_NRESET;
    logic        enable;
    logic [15:0] mem_rdata;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic        mem_we;
    logic [4:0]  status_flags;
    logic [15:0] pc;

    logic [15:0] mem [256];
    int          prog_len;
    int          prog_cycles;
    int          cycle_count;
    integer      seed;

    cr16_top i_dut (
        .I_CLK(I_CLK), .I_NRESET(I_NRESET), .enable(enable), .mem_rdata(mem_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .status_flags(status_flags), .pc(pc)
    );

    initial begin
        I_CLK = 1'b0;
        forever #10 I_CLK = ~I_CLK;
    end

    // Memory with one cycle of read latency, frozen while the core is stalled
    always @(posedge I_CLK) begin
        if (mem_we) begin
            mem[mem_addr[7:0]] <= mem_wdata;
        end
        if (enable) begin
            mem_rdata <= mem[mem_addr[7:0]];
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge I_CLK);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

    task automatic compare_values(input string label, input logic [15:0] expected,
                                  input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %h got %h", $time, label, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] ext, input logic [3:0] rs);
        return {op, rd, ext, rs};
    endfunction

    function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    // Opcode F with extension E is a no-op, the other fields carry the address
    function automatic logic [15:0] fill_word(input logic [7:0] addr);
        return {4'hf, addr[7:4], 4'he, addr[3:0]};
    endfunction

    // Expected flags {N, Z, F, L, C} of b + a or b - a
    function automatic logic [4:0] model_flags(input logic [15:0] b, input logic [15:0] a,
                                               input bit sub);
        int          sb;
        int          sa;
        int          s;
        int          u;
        logic [15:0] r;
        sb = $signed(b);
        sa = $signed(a);
        if (sub) begin
            s = sb - sa;
            u = int'(b) - int'(a);
            r = b - a;
            return {sb < sa, r == 16'h0, s > 32767 || s < -32768, u < 0, u < 0};
        end
        s = sb + sa;
        u = int'(b) + int'(a);
        r = b + a;
        return {1'b0, r == 16'h0, s > 32767 || s < -32768, 1'b0, u > 65535};
    endfunction

    // Puts the core in reset and clears memory for a fresh program
    task automatic new_program();
        @(posedge I_CLK);
        I_NRESET <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        prog_len    = 0;
        prog_cycles = 0;
    endtask

    task automatic emit(input logic [15:0] word, input int cycles);
        mem[prog_len] = word;
        prog_len++;
        prog_cycles += cycles;
    endtask

    // Builds a full constant through r14
    task automatic set_reg(input logic [3:0] rd, input logic [15:0] value);
        emit(imm_word(op_moviu, rd, value[15:8]), 3);
        emit(imm_word(op_movil, 4'd14, value[7:0]), 3);
        emit(reg_word(op_ext_alu, rd, ext_or, 4'd14), 3);
    endtask

    // Address goes through r13
    task automatic store_reg(input logic [3:0] rs, input logic [7:0] addr);
        emit(imm_word(op_movil, 4'd13, addr), 3);
        emit(reg_word(op_ext_misc, 4'd13, ext_store, rs), 3);
    endtask

    // Releases reset and runs the program, with an optional 20 cycle stall
    task automatic run_prog(input int stall_at, input int watch_addr);
        logic [15:0] pc_frozen;
        logic [15:0] data_frozen;
        repeat (10) @(posedge I_CLK);
        I_NRESET <= 1'b1;
        for (int i = 0; i < prog_cycles; i++) begin
            if (i == stall_at) begin
                enable <= 1'b0;
                @(negedge I_CLK);
                pc_frozen   = pc;
                data_frozen = mem[watch_addr];
                repeat (19) @(posedge I_CLK);
                @(negedge I_CLK);
                compare_values("pc during stall", pc_frozen, pc);
                compare_values("memory during stall", data_frozen, mem[watch_addr]);
                @(posedge I_CLK);
                enable <= 1'b1;
            end
            @(posedge I_CLK);
        end
        @(negedge I_CLK);
        compare_values("pc at end", prog_len, pc);
    endtask

    task automatic constant_moves();
        new_program();
        emit(imm_word(op_moviu, 4'd1, 8'ha5), 3);
        store_reg(4'd1, 8'd128);
        emit(imm_word(op_movil, 4'd2, 8'h3c), 3);
        store_reg(4'd2, 8'd129);
        emit(imm_word(op_movil, 4'd3, 8'hf0), 3);
        store_reg(4'd3, 8'd130);
        emit(reg_word(op_ext_alu, 4'd1, ext_or, 4'd2), 3);
        store_reg(4'd1, 8'd131);
        run_prog(-1, 0);
        compare_values("moviu", 16'ha500, mem[128]);
        compare_values("movil", 16'h003c, mem[129]);
        compare_values("movil high bit", 16'h00f0, mem[130]);
        compare_values("upper and lower bytes", 16'ha53c, mem[131]);
    endtask

    task automatic alu_results();
        logic [15:0] b;
        logic [15:0] a;
        logic [15:0] ops [10];
        logic [15:0] want [10];
        b = 16'h1234;
        a = 16'h0f0f;
        ops[0] = reg_word(op_ext_alu, 4'd3, ext_add, 4'd2);
        ops[1] = reg_word(op_ext_alu, 4'd3, ext_sub, 4'd2);
        ops[2] = reg_word(op_ext_alu, 4'd3, ext_and, 4'd2);
        ops[3] = reg_word(op_ext_alu, 4'd3, ext_or, 4'd2);
        ops[4] = reg_word(op_ext_alu, 4'd3, ext_xor, 4'd2);
        ops[5] = imm_word(op_addi, 4'd3, 8'hf6);
        ops[6] = imm_word(op_subi, 4'd3, 8'h05);
        ops[7] = imm_word(op_andi, 4'd3, 8'hf0);
        ops[8] = imm_word(op_ori, 4'd3, 8'h81);
        ops[9] = imm_word(op_xori, 4'd3, 8'hc3);
        want = '{b + a, b - a, b & a, b | a, b ^ a,
                 b - 16'd10, b - 16'd5, b & 16'h00f0, b | 16'h0081, b ^ 16'h00c3};
        new_program();
        set_reg(4'd1, b);
        set_reg(4'd2, a);
        for (int k = 0; k < 10; k++) begin
            emit(reg_word(op_ext_misc, 4'd3, ext_mov, 4'd1), 3);
            emit(ops[k], 3);
            store_reg(4'd3, 128 + k);
        end
        run_prog(-1, 0);
        for (int k = 0; k < 10; k++) begin
            compare_values($sformatf("alu op %0d", k), want[k], mem[128 + k]);
        end
    endtask

    // Immediate form takes a as the sign-extended low byte
    task automatic cmp_flags(input logic [15:0] b, input logic [15:0] a, input bit imm_form);
        new_program();
        set_reg(4'd1, b);
        if (imm_form) begin
            emit(imm_word(op_cmpi, 4'd1, a[7:0]), 3);
        end else begin
            set_reg(4'd2, a);
            emit(reg_word(op_ext_alu, 4'd1, ext_cmp, 4'd2), 3);
        end
        store_reg(4'd1, 8'd144);
        run_prog(-1, 0);
        compare_values($sformatf("flags of %h cmp %h", b, a), model_flags(b, a, 1'b1),
                       status_flags);
        compare_values("rdest after cmp", b, mem[144]);
    endtask

    task automatic load_and_copy();
        logic [15:0] data;
        data = $random(seed);
        new_program();
        mem[140] = data;
        emit(imm_word(op_movil, 4'd5, 8'd140), 3);
        emit(reg_word(op_ext_misc, 4'd4, ext_load, 4'd5), 4);
        store_reg(4'd4, 8'd141);
        emit(reg_word(op_ext_misc, 4'd6, ext_mov, 4'd4), 3);
        store_reg(4'd6, 8'd142);
        run_prog(-1, 0);
        compare_values("load then store", data, mem[141]);
        compare_values("mov copy", data, mem[142]);
    endtask

    // First pass runs straight, second stalls in the cycle of the first store
    task automatic stall_freeze();
        for (int pass = 0; pass < 2; pass++) begin
            new_program();
            set_reg(4'd1, 16'h1357);
            set_reg(4'd2, 16'h2468);
            emit(reg_word(op_ext_alu, 4'd1, ext_add, 4'd2), 3);
            store_reg(4'd1, 8'd150);
            emit(reg_word(op_ext_alu, 4'd2, ext_xor, 4'd1), 3);
            store_reg(4'd2, 8'd151);
            run_prog(pass == 1 ? 26 : -1, 150);
            compare_values($sformatf("sum in pass %0d", pass), 16'h1357 + 16'h2468, mem[150]);
            compare_values($sformatf("xor in pass %0d", pass),
                           16'h2468 ^ (16'h1357 + 16'h2468), mem[151]);
        end
    endtask

    // Odd rounds end on SUB and even rounds on ADD, so both flag rules are seen
    task automatic random_operands();
        logic [15:0] b;
        logic [15:0] a;
        bit          last_sub;
        for (int k = 0; k < 10; k++) begin
            b        = $random(seed);
            a        = $random(seed);
            last_sub = k[0];
            new_program();
            set_reg(4'd1, b);
            set_reg(4'd2, a);
            emit(reg_word(op_ext_misc, 4'd3, ext_mov, 4'd1), 3);
            emit(reg_word(op_ext_alu, 4'd3, last_sub ? ext_add : ext_sub, 4'd2), 3);
            store_reg(4'd3, 8'd160);
            emit(reg_word(op_ext_misc, 4'd4, ext_mov, 4'd1), 3);
            emit(reg_word(op_ext_alu, 4'd4, last_sub ? ext_sub : ext_add, 4'd2), 3);
            store_reg(4'd4, 8'd161);
            run_prog(-1, 0);
            compare_values($sformatf("round %0d first", k), last_sub ? b + a : b - a, mem[160]);
            compare_values($sformatf("round %0d second", k), last_sub ? b - a : b + a, mem[161]);
            compare_values($sformatf("round %0d flags", k), model_flags(b, a, last_sub),
                           status_flags);
        end
    endtask

    initial begin
        seed      = 32'hbb4f;
        I_NRESET  = 1'b0;
        enable    = 1'b1;
        mem_rdata = '0;
        constant_moves();
        alu_results();
        // Equal, unsigned less with overflow, signed less, overflow, then immediates
        cmp_flags(16'h1234, 16'h1234, 1'b0);
        cmp_flags(16'h0001, 16'h8000, 1'b0);
        cmp_flags(16'hffff, 16'h0001, 1'b0);
        cmp_flags(16'h8000, 16'h0001, 1'b0);
        cmp_flags(16'h0005, 16'hfff9, 1'b1);
        cmp_flags(16'h0003, 16'h0003, 1'b1);
        load_and_copy();
        stall_freeze();
        random_operands();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/cr16_alu.sv ====
// CR16 ALU computing b op a with carry, low, overflow, zero and negative flags
module cr16_alu (
    input  cr16_core_pkg::alu_op_t                op,
    input  logic [cr16_isa_pkg::word_w-1:0]       a,
    input  logic [cr16_isa_pkg::word_w-1:0]       b,
    output logic [cr16_isa_pkg::word_w-1:0]       result,
    output logic [cr16_core_pkg::flags_w-1:0]     flags
);
    import cr16_isa_pkg::*;
    import cr16_core_pkg::*;

    // One extra bit holds carry out or borrow
    logic [word_w:0] sum;
    logic [word_w:0] diff;

    assign sum  = {1'b0, b} + {1'b0, a};
    assign diff = {1'b0, b} - {1'b0, a};

    always_comb begin
        flags = '0;
        case (op)
            alu_add: begin
                result        = sum[word_w-1:0];
                flags[flag_c] = sum[word_w];
                // Same operand signs but the sign of the sum flipped
                flags[flag_f] = (a[word_w-1] == b[word_w-1]) &&
                                (result[word_w-1] != b[word_w-1]);
            end
            alu_sub: begin
                result        = diff[word_w-1:0];
                flags[flag_c] = diff[word_w];
                flags[flag_l] = b < a;
                flags[flag_f] = (a[word_w-1] != b[word_w-1]) &&
                                (result[word_w-1] != b[word_w-1]);
                flags[flag_n] = $signed(b) < $signed(a);
            end
            alu_and: result = b & a;
            alu_or:  result = b | a;
            alu_xor: result = b ^ a;
            default: result = b;
        endcase
        flags[flag_z] = (result == '0);
    end

endmodule

// ==== verilog/cr16_control.sv ====
// CR16 controller holding the FSM, instruction register, program counter and flags
module cr16_control (
    input  logic                                I_CLK,
    input  logic                                I_NRESET,
    input  logic                                enable,
    input  logic [cr16_isa_pkg::word_w-1:0]     mem_rdata,
    output logic [cr16_isa_pkg::word_w-1:0]     mem_addr,
    output logic [cr16_isa_pkg::word_w-1:0]     mem_wdata,
    output logic                                mem_we,
    output cr16_isa_pkg::instr_t                instr,
    input  cr16_core_pkg::instr_class_t         cls,
    input  logic [cr16_isa_pkg::word_w-1:0]     imm_value,
    input  logic                                imm_sel,
    input  logic [cr16_isa_pkg::word_w-1:0]     a_data,
    input  logic [cr16_isa_pkg::word_w-1:0]     b_data,
    input  logic [cr16_isa_pkg::word_w-1:0]     alu_result,
    input  logic [cr16_core_pkg::flags_w-1:0]   alu_flags,
    output logic                                rf_we,
    output logic [cr16_isa_pkg::word_w-1:0]     rf_wdata,
    output logic [cr16_core_pkg::flags_w-1:0]   status_flags,
    output logic [cr16_isa_pkg::word_w-1:0]     pc
);
    import cr16_isa_pkg::*;
    import cr16_core_pkg::*;

    state_t state;
    // Set when the next instruction was already captured during a store
    logic   instr_held;

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            state        <= st_fetch;
            pc           <= '0;
            instr        <= '0;
            status_flags <= '0;
            instr_held   <= 1'b0;
        end else if (enable) begin
            case (state)
                st_fetch: begin
                    if (!instr_held) begin
                        instr <= mem_rdata;
                    end
                    instr_held <= 1'b0;
                    pc         <= pc + 1'b1;
                    state      <= st_decode;
                end
                st_decode: begin
                    case (cls)
                        cls_alu, cls_cmp, cls_mov: state <= st_exec;
                        cls_load:  state <= st_load_addr;
                        cls_store: state <= st_store;
                        default:   state <= st_fetch;
                    endcase
                end
                st_exec: begin
                    if (cls == cls_alu || cls == cls_cmp) begin
                        status_flags <= alu_flags;
                    end
                    state <= st_fetch;
                end
                st_load_addr: state <= st_load_data;
                st_load_data: state <= st_fetch;
                st_store: begin
                    // The store cycle sees the word at pc from decode, so take it now
                    instr      <= mem_rdata;
                    instr_held <= 1'b1;
                    state      <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // Memory port follows the current state
    always_comb begin
        case (state)
            st_load_addr: mem_addr = a_data;
            st_store:     mem_addr = b_data;
            default:      mem_addr = pc;
        endcase
    end

    assign mem_wdata = a_data;
    assign mem_we    = enable && (state == st_store);

    // Register write back, always into rdest
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = alu_result;
        case (state)
            st_exec: begin
                if (cls == cls_alu) begin
                    rf_we = enable;
                end else if (cls == cls_mov) begin
                    rf_we = enable;
                    if (!imm_sel) begin
                        rf_wdata = a_data;
                    end else if (instr.imm_fmt.opcode == op_moviu) begin
                        rf_wdata = imm_value << imm_w;
                    end else begin
                        rf_wdata = imm_value;
                    end
                end
            end
            st_load_data: begin
                rf_we    = enable;
                rf_wdata = mem_rdata;
            end
            default: rf_we = 1'b0;
        endcase
    end

endmodule

// ==== verilog/cr16_core_pkg.sv ====
// CR16 core types for the ALU, the instruction classes, the FSM states and the flags
package cr16_core_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // What the controller has to do with a decoded instruction
    typedef enum logic [2:0] {
        cls_alu,
        cls_cmp,
        cls_mov,
        cls_load,
        cls_store,
        cls_nop
    } instr_class_t;

    // Status flag vector and bit positions
    localparam int flags_w = 5;
    localparam int flag_c  = 0;
    localparam int flag_l  = 1;
    localparam int flag_f  = 2;
    localparam int flag_z  = 3;
    localparam int flag_n  = 4;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_load_addr,
        st_load_data,
        st_store
    } state_t;

endpackage

// ==== verilog/cr16_decode.sv ====
// CR16 instruction decoder giving the class, the ALU operation and the extended immediate
module cr16_decode (
    input  cr16_isa_pkg::instr_t              instr,
    output cr16_core_pkg::instr_class_t       cls,
    output cr16_core_pkg::alu_op_t            alu_op,
    output logic [cr16_isa_pkg::word_w-1:0]   imm_value,
    output logic                              imm_sel
);
    import cr16_isa_pkg::*;
    import cr16_core_pkg::*;

    logic [word_w-1:0] imm_sext;
    logic [word_w-1:0] imm_zext;

    assign imm_sext = {{(word_w - imm_w){instr.imm_fmt.imm[imm_w-1]}}, instr.imm_fmt.imm};
    assign imm_zext = {{(word_w - imm_w){1'b0}}, instr.imm_fmt.imm};

    always_comb begin
        cls       = cls_nop;
        alu_op    = alu_pass_b;
        imm_value = '0;
        imm_sel   = 1'b0;
        case (instr.reg_fmt.opcode)
            op_ext_alu: begin
                cls = cls_alu;
                case (instr.reg_fmt.ext)
                    ext_add: alu_op = alu_add;
                    ext_sub: alu_op = alu_sub;
                    ext_cmp: begin
                        // Compare is a subtract that only sets flags
                        cls    = cls_cmp;
                        alu_op = alu_sub;
                    end
                    ext_and: alu_op = alu_and;
                    ext_or:  alu_op = alu_or;
                    ext_xor: alu_op = alu_xor;
                    default: cls = cls_nop;
                endcase
            end
            op_ext_misc: begin
                case (instr.reg_fmt.ext)
                    ext_mov:   cls = cls_mov;
                    ext_load:  cls = cls_load;
                    ext_store: cls = cls_store;
                    default:   cls = cls_nop;
                endcase
            end
            op_addi, op_subi, op_cmpi: begin
                cls       = (instr.imm_fmt.opcode == op_cmpi) ? cls_cmp : cls_alu;
                alu_op    = (instr.imm_fmt.opcode == op_addi) ? alu_add : alu_sub;
                imm_value = imm_sext;
                imm_sel   = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
                cls       = cls_alu;
                imm_value = imm_zext;
                imm_sel   = 1'b1;
                if (instr.imm_fmt.opcode == op_andi) begin
                    alu_op = alu_and;
                end else if (instr.imm_fmt.opcode == op_ori) begin
                    alu_op = alu_or;
                end else begin
                    alu_op = alu_xor;
                end
            end
            op_movil, op_moviu: begin
                // Upper byte placement is done by the controller
                cls       = cls_mov;
                imm_value = imm_zext;
                imm_sel   = 1'b1;
            end
            default: cls = cls_nop;
        endcase
    end

endmodule

// ==== verilog/cr16_isa_pkg.sv ====
// CR16 instruction set encoding shared by the decoder and the controller
package cr16_isa_pkg;

    // Field widths
    localparam int word_w    = 16;
    localparam int reg_idx_w = 4;
    localparam int opcode_w  = 4;
    localparam int ext_w     = 4;
    localparam int imm_w     = 8;

    // Major opcodes in bits 15:12
    localparam logic [opcode_w-1:0] op_ext_alu  = 4'b0000;
    localparam logic [opcode_w-1:0] op_addi     = 4'b0001;
    localparam logic [opcode_w-1:0] op_subi     = 4'b0100;
    localparam logic [opcode_w-1:0] op_cmpi     = 4'b0101;
    localparam logic [opcode_w-1:0] op_andi     = 4'b0111;
    localparam logic [opcode_w-1:0] op_ori      = 4'b1000;
    localparam logic [opcode_w-1:0] op_xori     = 4'b1001;
    localparam logic [opcode_w-1:0] op_movil    = 4'b1010;
    localparam logic [opcode_w-1:0] op_moviu    = 4'b1011;
    localparam logic [opcode_w-1:0] op_ext_misc = 4'b1111;

    // Extensions in bits 7:4 under op_ext_alu
    localparam logic [ext_w-1:0] ext_add = 4'b0000;
    localparam logic [ext_w-1:0] ext_sub = 4'b0011;
    localparam logic [ext_w-1:0] ext_cmp = 4'b0100;
    localparam logic [ext_w-1:0] ext_and = 4'b0110;
    localparam logic [ext_w-1:0] ext_or  = 4'b0111;
    localparam logic [ext_w-1:0] ext_xor = 4'b1000;

    // Extensions under op_ext_misc
    localparam logic [ext_w-1:0] ext_mov   = 4'b0001;
    localparam logic [ext_w-1:0] ext_load  = 4'b1010;
    localparam logic [ext_w-1:0] ext_store = 4'b1011;

    // Register form, opcode rdest ext rsrc
    typedef struct packed {
        logic [opcode_w-1:0]  opcode;
        logic [reg_idx_w-1:0] rdest;
        logic [ext_w-1:0]     ext;
        logic [reg_idx_w-1:0] rsrc;
    } reg_fmt_t;

    // Immediate form, the 8-bit immediate takes the ext and rsrc slots
    typedef struct packed {
        logic [opcode_w-1:0]  opcode;
        logic [reg_idx_w-1:0] rdest;
        logic [imm_w-1:0]     imm;
    } imm_fmt_t;

    typedef union packed {
        reg_fmt_t reg_fmt;
        imm_fmt_t imm_fmt;
    } instr_t;

endpackage

// ==== verilog/cr16_regfile.sv ====
// CR16 register file, sixteen words with two combinational reads and one write
module cr16_regfile (
    input  logic                                I_CLK,
    input  logic                                I_NRESET,
    input  logic [cr16_isa_pkg::reg_idx_w-1:0]  ra_idx,
    input  logic [cr16_isa_pkg::reg_idx_w-1:0]  rb_idx,
    input  logic                                we,
    input  logic [cr16_isa_pkg::reg_idx_w-1:0]  w_idx,
    input  logic [cr16_isa_pkg::word_w-1:0]     w_data,
    output logic [cr16_isa_pkg::word_w-1:0]     ra_data,
    output logic [cr16_isa_pkg::word_w-1:0]     rb_data
);
    import cr16_isa_pkg::*;

    logic [word_w-1:0] regs [2**reg_idx_w];

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[w_idx] <= w_data;
        end
    end

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

endmodule

// ==== verilog/cr16_top.sv ====
// CR16 processor top joining the controller, decoder, ALU and register file
module cr16_top (
    input  logic                                I_CLK,
    input  logic                                I_NRESET,
    input  logic                                enable,
    input  logic [cr16_isa_pkg::word_w-1:0]     mem_rdata,
    output logic [cr16_isa_pkg::word_w-1:0]     mem_addr,
    output logic [cr16_isa_pkg::word_w-1:0]     mem_wdata,
    output logic                                mem_we,
    output logic [cr16_core_pkg::flags_w-1:0]   status_flags,
    output logic [cr16_isa_pkg::word_w-1:0]     pc
);
    import cr16_isa_pkg::*;
    import cr16_core_pkg::*;

    instr_t             instr;
    instr_class_t       cls;
    alu_op_t            alu_op;
    logic [word_w-1:0]  imm_value;
    logic               imm_sel;
    logic [word_w-1:0]  ra_data;
    logic [word_w-1:0]  rb_data;
    logic [word_w-1:0]  alu_a;
    logic [word_w-1:0]  alu_result;
    logic [flags_w-1:0] alu_flags;
    logic               rf_we;
    logic [word_w-1:0]  rf_wdata;

    // Rsrc or the immediate feeds the ALU a side
    assign alu_a = imm_sel ? imm_value : ra_data;

    cr16_control i_control (
        .I_CLK(I_CLK), .I_NRESET(I_NRESET), .enable(enable),
        .mem_rdata(mem_rdata), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .instr(instr), .cls(cls), .imm_value(imm_value), .imm_sel(imm_sel),
        .a_data(ra_data), .b_data(rb_data), .alu_result(alu_result), .alu_flags(alu_flags),
        .rf_we(rf_we), .rf_wdata(rf_wdata), .status_flags(status_flags), .pc(pc)
    );

    cr16_decode i_decode (
        .instr(instr), .cls(cls), .alu_op(alu_op), .imm_value(imm_value), .imm_sel(imm_sel)
    );

    cr16_alu i_alu (
        .op(alu_op), .a(alu_a), .b(rb_data), .result(alu_result), .flags(alu_flags)
    );

    cr16_regfile i_regfile (
        .I_CLK(I_CLK), .I_NRESET(I_NRESET),
        .ra_idx(instr.reg_fmt.rsrc), .rb_idx(instr.reg_fmt.rdest),
        .we(rf_we), .w_idx(instr.reg_fmt.rdest), .w_data(rf_wdata),
        .ra_data(ra_data), .rb_data(rb_data)
    );

endmodule
